/* Bender.yml */
package:
  name: exe_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/exe_data_pkg.sv
      - hw/exe_op_pkg.sv
      - hw/alu_unit.sv
      - hw/branch_unit.sv
      - hw/div_ctrl_fsm.sv
      - hw/div_step_counter.sv
      - hw/div_datapath.sv
      - hw/exe_top.sv
  - target: test
    files:
      - test/exe_checker.sv
      - test/exe_tb.sv

/* hw/alu_unit.sv */
// Combinational 64-bit integer ALU
`default_nettype none

module alu_unit
    import exe_data_pkg::*;
    import exe_op_pkg::*;
(
    input  bus64_t  op_a_i,
    input  bus64_t  op_b_i,
    input  alu_op_t alu_op_i,
    output bus64_t  result_o
);

logic [5:0] shamt;
logic       lt_signed;
logic       lt_unsigned;

// RV64 shifts only look at the low six bits
assign shamt = op_b_i[5:0];

assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
assign lt_unsigned = op_a_i < op_b_i;

always_comb begin
    case (alu_op_i)
        ALU_ADD:  result_o = op_a_i + op_b_i;
        ALU_SUB:  result_o = op_a_i - op_b_i;
        ALU_AND:  result_o = op_a_i & op_b_i;
        ALU_OR:   result_o = op_a_i | op_b_i;
        ALU_XOR:  result_o = op_a_i ^ op_b_i;
        ALU_SLL:  result_o = op_a_i << shamt;
        ALU_SRL:  result_o = op_a_i >> shamt;
        ALU_SRA:  result_o = $signed(op_a_i) >>> shamt;
        // Set-less-than results are 0 or 1
        ALU_SLT:  result_o = bus64_t'(lt_signed);
        ALU_SLTU: result_o = bus64_t'(lt_unsigned);
        default:  result_o = '0;
    endcase
end

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
// Branch compare, jump target and link value computation
`default_nettype none

`include "exe_macros.svh"

module branch_unit
    import exe_data_pkg::*;
    import exe_op_pkg::*;
(
    input  branch_op_t branch_op_i,
    input  addr_t      pc_i,
    input  bus64_t     rs1_i,
    input  bus64_t     rs2_i,
    input  bus64_t     imm_i,
    output logic       taken_o,
    output addr_t      target_o,
    output bus64_t     link_o
);

addr_t pc_rel;
addr_t reg_rel;
logic  is_jump;
logic  eq;
logic  lt;
logic  ltu;

// Comparisons
assign eq  = rs1_i == rs2_i;
assign lt  = $signed(rs1_i) < $signed(rs2_i);
assign ltu = rs1_i < rs2_i;

assign pc_rel  = pc_i + imm_i;
assign reg_rel = rs1_i + imm_i;

assign is_jump = (branch_op_i == BR_JAL) || (branch_op_i == BR_JALR);

always_comb begin
    case (branch_op_i)
        BR_BEQ:  taken_o = eq;
        BR_BNE:  taken_o = !eq;
        BR_BLT:  taken_o = lt;
        BR_BGE:  taken_o = !lt;
        BR_BLTU: taken_o = ltu;
        BR_BGEU: taken_o = !ltu;
        default: taken_o = 1'b1;
    endcase
end

// jalr drops bit 0 of the computed address
assign target_o = (branch_op_i == BR_JALR) ? {reg_rel[`XLEN-1:1], 1'b0} : pc_rel;

// Only jumps write a return address
assign link_o = is_jump ? pc_i + `PC_INC : '0;

endmodule

`default_nettype wire

/* hw/div_ctrl_fsm.sv */
// Divider control FSM sequencing load, shift-subtract steps and fix-up, with kill
`default_nettype none

module div_ctrl_fsm
    import exe_op_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic req_i,
    input  logic kill_i,
    input  logic last_step_i,
    output logic cnt_load_o,
    output logic load_o,
    output logic step_en_o,
    output logic fix_o,
    output logic done_o,
    output logic busy_o
);

div_state_t state_q;
div_state_t state_d;

always_comb begin
    state_d = state_q;
    case (state_q)
        IDLE: begin
            if (req_i) begin
                state_d = LOAD;
            end
        end
        LOAD: state_d = RUN;
        RUN: begin
            if (last_step_i) begin
                state_d = FIX;
            end
        end
        default: state_d = IDLE;
    endcase
    // Abort wins over everything
    if (kill_i) begin
        state_d = IDLE;
    end
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        state_q <= IDLE;
    end else begin
        state_q <= state_d;
    end
end

assign load_o     = state_q == LOAD;
assign cnt_load_o = state_q == LOAD;
assign step_en_o  = state_q == RUN;
assign fix_o      = state_q == FIX;
assign done_o     = (state_q == FIX) && !kill_i;   // killed divide never completes
assign busy_o     = state_q != IDLE;

// --------------------------------------------------
// Checks
// --------------------------------------------------

// Upstream holds off while the stage stalls
a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_o |-> !req_i)
    else $error("divide request while divider busy");

a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o)
    else $error("done held for more than one cycle");

endmodule

`default_nettype wire

/* hw/div_datapath.sv */
// Radix-2 restoring divider datapath with sign handling and RISC-V special cases
`default_nettype none

module div_datapath
    import exe_data_pkg::*;
    import exe_op_pkg::*;
(
    input  logic    clk_i,
    input  logic    load_i,
    input  logic    step_en_i,
    input  logic    fix_i,
    input  div_op_t div_op_i,
    input  logic    word_op_i,
    input  bus64_t  dvnd_i,
    input  bus64_t  dvsr_i,
    output bus64_t  result_o
);

logic          signed_op;
logic          rem_op;
bus64_t        dvnd_ext;
bus64_t        dvsr_ext;
bus64_t        dvnd_mag;
bus64_t        dvsr_mag;
bus64_t        min_neg;
logic [64:0]   trial;
logic [64:0]   diff;
logic          q_bit;
bus64_t        quo_fix;
bus64_t        rem_fix;
bus64_t        res_sel;

// Iteration state
bus64_t quo_q;
bus64_t rem_q;
bus64_t dvsr_mag_q;
bus64_t dvnd_q;
logic   neg_quo_q;
logic   neg_rem_q;
logic   div_zero_q;
logic   ovf_q;

assign signed_op = (div_op_i == DIV) || (div_op_i == REM);
assign rem_op    = (div_op_i == REM) || (div_op_i == REMU);

// --------------------------------------------------
// Operand preparation
// --------------------------------------------------

always_comb begin
    dvnd_ext = dvnd_i;
    dvsr_ext = dvsr_i;
    if (word_op_i) begin
        dvnd_ext = {{32{signed_op & dvnd_i[31]}}, dvnd_i[31:0]};
        dvsr_ext = {{32{signed_op & dvsr_i[31]}}, dvsr_i[31:0]};
    end
end

assign dvnd_mag = (signed_op && dvnd_ext[63]) ? -dvnd_ext : dvnd_ext;
assign dvsr_mag = (signed_op && dvsr_ext[63]) ? -dvsr_ext : dvsr_ext;

// Most negative value of the operand width
assign min_neg = word_op_i ? 64'hFFFF_FFFF_8000_0000 : 64'h8000_0000_0000_0000;

// --------------------------------------------------
// Shift-subtract step
// --------------------------------------------------

assign trial = {rem_q, quo_q[63]};
assign diff  = trial - {1'b0, dvsr_mag_q};
assign q_bit = !diff[64];

always_ff @(posedge clk_i) begin
    if (load_i) begin
        // Word dividend sits in the top half so 32 steps consume it
        quo_q      <= word_op_i ? {dvnd_mag[31:0], 32'b0} : dvnd_mag;
        rem_q      <= '0;
        dvsr_mag_q <= dvsr_mag;
        dvnd_q     <= dvnd_ext;
        neg_quo_q  <= signed_op && (dvnd_ext[63] ^ dvsr_ext[63]);
        neg_rem_q  <= signed_op && dvnd_ext[63];
        div_zero_q <= dvsr_ext == '0;
        ovf_q      <= signed_op && (dvnd_ext == min_neg) && (&dvsr_ext);
    end else if (step_en_i) begin
        rem_q <= q_bit ? diff[63:0] : trial[63:0];
        quo_q <= {quo_q[62:0], q_bit};
    end
end

// --------------------------------------------------
// Fix-up and result select
// --------------------------------------------------

always_comb begin
    quo_fix = neg_quo_q ? -quo_q : quo_q;
    rem_fix = neg_rem_q ? -rem_q : rem_q;
    if (div_zero_q) begin
        quo_fix = '1;
        rem_fix = dvnd_q;
    end else if (ovf_q) begin
        quo_fix = dvnd_q;
        rem_fix = '0;
    end
    res_sel = rem_op ? rem_fix : quo_fix;
    if (word_op_i) begin
        res_sel = {{32{res_sel[31]}}, res_sel[31:0]};
    end
end

// Only meaningful in the fix cycle
assign result_o = fix_i ? res_sel : '0;

endmodule

`default_nettype wire

/* hw/div_step_counter.sv */
// Down-counter of remaining divider steps
`default_nettype none

`include "exe_macros.svh"

module div_step_counter (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic load_i,
    input  logic word_op_i,
    input  logic step_en_i,
    output logic last_step_o
);

logic [`STEP_CNT_W-1:0] cnt_q;

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        cnt_q <= '0;
    end else if (load_i) begin
        cnt_q <= word_op_i ? `STEP_CNT_W'(`DIV_STEPS_W - 1) : `STEP_CNT_W'(`DIV_STEPS_D - 1);
    end else if (step_en_i && (cnt_q != '0)) begin
        cnt_q <= cnt_q - 1'b1;
    end
end

assign last_step_o = step_en_i && (cnt_q == '0);

// After the final step no further step may come before a reload
a_no_step_past_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (step_en_i && (cnt_q == '0)) |=> (!step_en_i until load_i))
    else $error("divider step after final step without reload");

endmodule

`default_nettype wire

/* hw/exe_data_pkg.sv */
// Data types for machine words, program addresses and register indices
`default_nettype none

`include "exe_macros.svh"

package exe_data_pkg;

    // Register contents and unit results
    typedef logic [`XLEN-1:0] bus64_t;

    // Program counter and branch targets
    typedef logic [`XLEN-1:0] addr_t;

    // Architectural register number, x0 is hardwired zero
    typedef logic [`REG_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

/* hw/exe_macros.svh */
// Data and index widths, divider step counts, link offset
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// Datapath widths
`define XLEN 64
`define REG_W 5

// Divider schedule, one quotient bit per step
`define DIV_STEPS_D 64
`define DIV_STEPS_W 32

// Holds the largest step count minus one
`define STEP_CNT_W 7

// Link value offset for jal and jalr
`define PC_INC 4

`endif

/* hw/exe_op_pkg.sv */
// Encodings for unit select, ALU ops, branch ops, divide ops and divider states
`default_nettype none

package exe_op_pkg;

    // Target functional unit of an instruction
    typedef enum logic [1:0] {
        UNIT_NONE   = 2'b00,
        UNIT_ALU    = 2'b01,
        UNIT_BRANCH = 2'b10,
        UNIT_DIV    = 2'b11
    } fu_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // Conditional branches first, then the two jumps
    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } branch_op_t;

    // Bit 0 set means unsigned, bit 1 set means remainder
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    // Divider sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        RUN  = 2'd2,
        FIX  = 2'd3
    } div_state_t;

endpackage

`default_nettype wire

/* hw/exe_top.sv */
// Execution stage: bypass, operand select, ALU, branch unit, divider, write-back register
`default_nettype none

module exe_top
    import exe_data_pkg::*;
    import exe_op_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  logic       kill_i,

    // Decoded operation
    input  fu_sel_t    fu_sel_i,
    input  alu_op_t    alu_op_i,
    input  branch_op_t branch_op_i,
    input  div_op_t    div_op_i,
    input  logic       word_op_i,

    // Operands from register read
    input  addr_t      pc_i,
    input  reg_idx_t   rs1_idx_i,
    input  reg_idx_t   rs2_idx_i,
    input  bus64_t     rs1_data_i,
    input  bus64_t     rs2_data_i,
    input  bus64_t     imm_i,
    input  logic       use_imm_i,
    input  reg_idx_t   rd_i,

    // Forwarding from write-back
    input  logic       wb_fwd_valid_i,
    input  reg_idx_t   wb_fwd_rd_i,
    input  bus64_t     wb_fwd_data_i,

    output logic       wb_valid_o,
    output reg_idx_t   wb_rd_o,
    output bus64_t     wb_result_o,
    output logic       wb_taken_o,
    output addr_t      wb_target_o,
    output logic       stall_o
);

bus64_t rs1_byp;
bus64_t rs2_byp;
bus64_t rs2_op;

logic   accept;
logic   alu_go;
logic   br_go;
logic   div_req;

bus64_t alu_result;
logic   br_taken;
addr_t  br_target;
bus64_t br_link;

// Divider handshake
logic   div_cnt_load;
logic   div_load;
logic   div_step_en;
logic   div_fix;
logic   div_done;
logic   div_busy;
logic   div_last_step;
bus64_t div_result;

// Divide held for the duration of the run
reg_idx_t div_rd_q;
div_op_t  div_op_q;
logic     div_word_q;
bus64_t   dvnd_q;
bus64_t   dvsr_q;

// --------------------------------------------------
// Bypass and operand select
// --------------------------------------------------

// x0 never takes a forwarded value
assign rs1_byp = (wb_fwd_valid_i && (wb_fwd_rd_i == rs1_idx_i) && (rs1_idx_i != '0)) ?
                 wb_fwd_data_i : rs1_data_i;
assign rs2_byp = (wb_fwd_valid_i && (wb_fwd_rd_i == rs2_idx_i) && (rs2_idx_i != '0)) ?
                 wb_fwd_data_i : rs2_data_i;

assign rs2_op = use_imm_i ? imm_i : rs2_byp;

// Inputs are dropped while a divide is in flight
assign accept  = valid_i && !stall_o;
assign alu_go  = accept && (fu_sel_i == UNIT_ALU);
assign br_go   = accept && (fu_sel_i == UNIT_BRANCH);
assign div_req = accept && (fu_sel_i == UNIT_DIV);

always_ff @(posedge clk_i) begin
    if (div_req) begin
        div_rd_q   <= rd_i;
        div_op_q   <= div_op_i;
        div_word_q <= word_op_i;
        dvnd_q     <= rs1_byp;
        dvsr_q     <= rs2_op;
    end
end

// --------------------------------------------------
// Functional units
// --------------------------------------------------

alu_unit alu_unit_inst (
    .op_a_i   (rs1_byp),
    .op_b_i   (rs2_op),
    .alu_op_i (alu_op_i),
    .result_o (alu_result)
);

// Branches always compare the registers, never the immediate
branch_unit branch_unit_inst (
    .branch_op_i (branch_op_i),
    .pc_i        (pc_i),
    .rs1_i       (rs1_byp),
    .rs2_i       (rs2_byp),
    .imm_i       (imm_i),
    .taken_o     (br_taken),
    .target_o    (br_target),
    .link_o      (br_link)
);

div_ctrl_fsm div_ctrl_fsm_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (div_req),
    .kill_i      (kill_i),
    .last_step_i (div_last_step),
    .cnt_load_o  (div_cnt_load),
    .load_o      (div_load),
    .step_en_o   (div_step_en),
    .fix_o       (div_fix),
    .done_o      (div_done),
    .busy_o      (div_busy)
);

div_step_counter div_step_counter_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .load_i      (div_cnt_load),
    .word_op_i   (div_word_q),
    .step_en_i   (div_step_en),
    .last_step_o (div_last_step)
);

div_datapath div_datapath_inst (
    .clk_i     (clk_i),
    .load_i    (div_load),
    .step_en_i (div_step_en),
    .fix_i     (div_fix),
    .div_op_i  (div_op_q),
    .word_op_i (div_word_q),
    .dvnd_i    (dvnd_q),
    .dvsr_i    (dvsr_q),
    .result_o  (div_result)
);

assign stall_o = div_busy;

// --------------------------------------------------
// Write-back register
// --------------------------------------------------

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        wb_valid_o <= 1'b0;
    end else begin
        wb_valid_o <= alu_go || br_go || div_done;
    end
end

always_ff @(posedge clk_i) begin
    if (div_done) begin
        wb_rd_o     <= div_rd_q;
        wb_result_o <= div_result;
        wb_taken_o  <= 1'b0;
        wb_target_o <= '0;
    end else if (br_go) begin
        wb_rd_o     <= rd_i;
        wb_result_o <= br_link;
        wb_taken_o  <= br_taken;
        wb_target_o <= br_target;
    end else if (alu_go) begin
        wb_rd_o     <= rd_i;
        wb_result_o <= alu_result;
        wb_taken_o  <= 1'b0;
        wb_target_o <= '0;
    end
end

// Stall covers the fix cycle, so the write-back port is never contended
a_no_wb_clash: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !((alu_go || br_go) && div_done))
    else $error("instruction accepted in divider done cycle");

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/exe_data_pkg.sv
hw/exe_op_pkg.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/div_ctrl_fsm.sv
hw/div_step_counter.sv
hw/div_datapath.sv
hw/exe_top.sv
test/exe_checker.sv
test/exe_tb.sv

/* test/exe_checker.sv */
// Testbench checker comparing write-back outputs with expected values and counting tests
`default_nettype none

module exe_checker
    import exe_data_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Watched DUT signals
    input  logic        wb_valid_i,
    input  reg_idx_t    wb_rd_i,
    input  bus64_t      wb_result_i,
    input  logic        wb_taken_i,
    input  addr_t       wb_target_i,
    input  logic        stall_i,
    input  logic        kill_i,
    input  logic        fast_issue_i,
    input  logic        div_issue_i,

    // Expectations for the running test
    input  logic [15:0] test_idx_i,
    input  logic        exp_wb_i,
    input  reg_idx_t    exp_rd_i,
    input  bus64_t      exp_result_i,
    input  logic        exp_taken_i,
    input  addr_t       exp_target_i,
    input  logic        missing_i,
    input  logic        nowb_done_i,

    output logic [15:0] pass_cnt_o,
    output logic [15:0] fail_cnt_o
);

logic test_err;
logic reset_seen;
logic kill_q;
logic stall_q;
logic fast_q;
logic div_q;

initial begin
    pass_cnt_o = '0;
    fail_cnt_o = '0;
    test_err   = 1'b0;
    reset_seen = 1'b0;
    kill_q     = 1'b0;
    stall_q    = 1'b0;
    fast_q     = 1'b0;
    div_q      = 1'b0;
end

// One line per finished test
task automatic report_test();
    if (test_err) begin
        fail_cnt_o = fail_cnt_o + 1'b1;
        $display("Test %0d failed", test_idx_i);
    end else begin
        pass_cnt_o = pass_cnt_o + 1'b1;
        $display("Test %0d passed", test_idx_i);
    end
    test_err = 1'b0;
endtask

task automatic compare_wb();
    if (wb_rd_i !== exp_rd_i) begin
        $display("Fail test %0d wb_rd_o got %h expected %h", test_idx_i, wb_rd_i, exp_rd_i);
        test_err = 1'b1;
    end
    if (wb_result_i !== exp_result_i) begin
        $display("Fail test %0d wb_result_o got %h expected %h",
                 test_idx_i, wb_result_i, exp_result_i);
        test_err = 1'b1;
    end
    if (wb_taken_i !== exp_taken_i) begin
        $display("Fail test %0d wb_taken_o got %h expected %h",
                 test_idx_i, wb_taken_i, exp_taken_i);
        test_err = 1'b1;
    end
    if (wb_target_i !== exp_target_i) begin
        $display("Fail test %0d wb_target_o got %h expected %h",
                 test_idx_i, wb_target_i, exp_target_i);
        test_err = 1'b1;
    end
endtask

// --------------------------------------------------
// Sampling on the rising edge, outputs hold last cycle's values
// --------------------------------------------------

always @(posedge clk_i) begin
    if (rst_n_i) begin
        if (!reset_seen) begin
            reset_seen = 1'b1;
            if ((wb_valid_i !== 1'b0) || (stall_i !== 1'b0)) begin
                $display("Reset state wrong, write-back valid or stall is high after reset");
                fail_cnt_o = fail_cnt_o + 1'b1;
            end
        end
        if (kill_q && stall_i) begin
            $display("Test %0d: stall still high the cycle after kill", test_idx_i);
            test_err = 1'b1;
        end
        if (div_q && !stall_i) begin
            $display("Test %0d: stall not raised after the divide request", test_idx_i);
            test_err = 1'b1;
        end
        // ALU and branch results are due one cycle after issue
        if (fast_q && !wb_valid_i) begin
            $display("Test %0d: result did not arrive one cycle after issue", test_idx_i);
            test_err = 1'b1;
        end
        // Divide result must come out as the stall ends
        if (stall_q && !stall_i && !kill_q && !wb_valid_i) begin
            $display("Test %0d: stall dropped before the divide result arrived", test_idx_i);
            test_err = 1'b1;
        end
        if (wb_valid_i) begin
            if (!exp_wb_i) begin
                $display("Test %0d: write-back arrived for a killed divide", test_idx_i);
                test_err = 1'b1;
            end else begin
                compare_wb();
                report_test();
            end
        end
        if (missing_i) begin
            $display("Test %0d: no write-back arrived before the wait ran out", test_idx_i);
            test_err = 1'b1;
            report_test();
        end
        if (nowb_done_i) begin
            report_test();
        end
        kill_q  = kill_i;
        stall_q = stall_i;
        fast_q  = fast_issue_i;
        div_q   = div_issue_i;
    end
end

endmodule

`default_nettype wire

/* test/exe_tb.sv */
// Testbench top: clock, reset, vector file, falling-edge drive, random ALU tests, watchdog
`default_nettype none

module exe_tb
    import exe_data_pkg::*;
    import exe_op_pkg::*;
();

localparam int NUM_FILE_VEC = 35;
localparam int NUM_RAND     = 8;
localparam int NUM_VEC      = NUM_FILE_VEC + NUM_RAND;
localparam int WORDS        = 10;
localparam int PERIOD       = 40;

logic       clk;
logic       rst_n;
logic       valid;
logic       kill;
fu_sel_t    fu_sel;
alu_op_t    alu_op;
branch_op_t branch_op;
div_op_t    div_op;
logic       word_op;
addr_t      pc;
reg_idx_t   rs1_idx;
reg_idx_t   rs2_idx;
bus64_t     rs1_data;
bus64_t     rs2_data;
bus64_t     imm;
logic       use_imm;
reg_idx_t   rd;
logic       fwd_valid;
reg_idx_t   fwd_rd;
bus64_t     fwd_data;

logic       wb_valid;
reg_idx_t   wb_rd;
bus64_t     wb_result;
logic       wb_taken;
addr_t      wb_target;
logic       stall;

// Checker side
logic [15:0] test_idx;
logic        exp_wb;
reg_idx_t    exp_rd;
bus64_t      exp_result;
logic        exp_taken;
addr_t       exp_target;
logic        missing;
logic        nowb_done;
logic [15:0] pass_cnt;
logic [15:0] fail_cnt;

logic [63:0] vec_mem [0:NUM_FILE_VEC*WORDS-1];
logic [31:0] lfsr_q;

exe_top DUT (
    .clk_i(clk), .rst_n_i(rst_n), .valid_i(valid), .kill_i(kill),
    .fu_sel_i(fu_sel), .alu_op_i(alu_op), .branch_op_i(branch_op),
    .div_op_i(div_op), .word_op_i(word_op),
    .pc_i(pc), .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm),
    .use_imm_i(use_imm), .rd_i(rd),
    .wb_fwd_valid_i(fwd_valid), .wb_fwd_rd_i(fwd_rd), .wb_fwd_data_i(fwd_data),
    .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_result_o(wb_result),
    .wb_taken_o(wb_taken), .wb_target_o(wb_target), .stall_o(stall)
);

exe_checker wb_checker (
    .clk_i(clk), .rst_n_i(rst_n),
    .wb_valid_i(wb_valid), .wb_rd_i(wb_rd), .wb_result_i(wb_result),
    .wb_taken_i(wb_taken), .wb_target_i(wb_target), .stall_i(stall), .kill_i(kill),
    .fast_issue_i(valid && ((fu_sel == UNIT_ALU) || (fu_sel == UNIT_BRANCH))),
    .div_issue_i(valid && (fu_sel == UNIT_DIV)),
    .test_idx_i(test_idx), .exp_wb_i(exp_wb), .exp_rd_i(exp_rd),
    .exp_result_i(exp_result), .exp_taken_i(exp_taken), .exp_target_i(exp_target),
    .missing_i(missing), .nowb_done_i(nowb_done),
    .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
);

initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
end

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic rand_word(output bus64_t v);
    v = '0;
    for (int i = 0; i < 64; i++) begin
        v = {v[62:0], lfsr_q[0]};
        lfsr_q = lfsr_next(lfsr_q);
    end
endtask

// ctrl nibbles: unit alu branch div word imm fwd kill
task automatic run_vector(input logic [31:0] ctrl, input logic [31:0] idx,
                          input bus64_t v_pc, input bus64_t v_rs1, input bus64_t v_rs2,
                          input bus64_t v_imm, input bus64_t v_fwd, input logic [63:0] tr,
                          input bus64_t res, input bus64_t tgt, input int num);
    int waited;
    test_idx   = num[15:0];
    exp_wb     = !ctrl[0];
    exp_rd     = tr[4:0];
    exp_taken  = tr[8];
    exp_result = res;
    exp_target = tgt;
    fu_sel     = fu_sel_t'(ctrl[29:28]);
    alu_op     = alu_op_t'(ctrl[27:24]);
    branch_op  = branch_op_t'(ctrl[22:20]);
    div_op     = div_op_t'(ctrl[17:16]);
    word_op    = ctrl[12];
    use_imm    = ctrl[8];
    fwd_valid  = ctrl[4];
    rs1_idx    = idx[28:24];
    rs2_idx    = idx[20:16];
    rd         = idx[12:8];
    fwd_rd     = idx[4:0];
    pc         = v_pc;
    rs1_data   = v_rs1;
    rs2_data   = v_rs2;
    imm        = v_imm;
    fwd_data   = v_fwd;
    valid      = 1'b1;
    @(negedge clk);
    valid     = 1'b0;
    fwd_valid = 1'b0;
    if (ctrl[0]) begin
        // Abort the divide partway, then watch that nothing comes out
        repeat (10) @(negedge clk);
        kill = 1'b1;
        @(negedge clk);
        kill = 1'b0;
        repeat (80) @(negedge clk);
        nowb_done = 1'b1;
        @(negedge clk);
        nowb_done = 1'b0;
    end else begin
        waited = 0;
        while (!wb_valid && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_valid) begin
            missing = 1'b1;
            @(negedge clk);
            missing = 1'b0;
        end else begin
            @(negedge clk);
        end
    end
endtask

initial begin
    int     b;
    bus64_t a_val;
    bus64_t b_val;
    logic   use_xor;
    rst_n = 1'b0;
    valid = 1'b0;
    kill = 1'b0;
    fu_sel = UNIT_NONE;
    alu_op = ALU_ADD;
    branch_op = BR_BEQ;
    div_op = DIV;
    word_op = 1'b0;
    pc = '0;
    rs1_idx = '0;
    rs2_idx = '0;
    rs1_data = '0;
    rs2_data = '0;
    imm = '0;
    use_imm = 1'b0;
    rd = '0;
    fwd_valid = 1'b0;
    fwd_rd = '0;
    fwd_data = '0;
    test_idx = '0;
    exp_wb = 1'b1;
    exp_rd = '0;
    exp_result = '0;
    exp_taken = 1'b0;
    exp_target = '0;
    missing = 1'b0;
    nowb_done = 1'b0;
    lfsr_q = 32'd34;
    $readmemh("test/exe_tests.hex", vec_mem);
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    for (int t = 0; t < NUM_FILE_VEC; t++) begin
        b = t * WORDS;
        run_vector(vec_mem[b][31:0], vec_mem[b+1][31:0], vec_mem[b+2], vec_mem[b+3],
                   vec_mem[b+4], vec_mem[b+5], vec_mem[b+6], vec_mem[b+7],
                   vec_mem[b+8], vec_mem[b+9], t + 1);
    end

    // Random add and xor, expected value from the op itself
    for (int r = 0; r < NUM_RAND; r++) begin
        use_xor = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        rand_word(a_val);
        rand_word(b_val);
        run_vector(use_xor ? 32'h1400_0000 : 32'h1000_0000, 32'h0102_0900, 64'h1000,
                   a_val, b_val, 64'h0, 64'h0, 64'h009,
                   use_xor ? (a_val ^ b_val) : (a_val + b_val), 64'h0,
                   NUM_FILE_VEC + r + 1);
    end

    repeat (2) @(negedge clk);
    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == NUM_VEC) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

// Watchdog sized from the vector count plus reset
initial begin
    #((NUM_VEC * 80 + 16) * PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $finish;
end

endmodule

`default_nettype wire

/* test/exe_tests.hex */
// ctrl(unit alu br div word imm fwd kill) idx(rs1 rs2 rd fwd_rd) pc rs1 rs2 imm fwd_data
// exp(taken<<8 | rd) exp_result exp_target
10000000 01020300 1000 5 7 0 0 003 c 0
11000000 01020400 1000 5 7 0 0 004 fffffffffffffffe 0
12000100 01020500 1000 f0f0 1234 0ff0 0 005 f0 0
13000000 01020600 1000 f000 f 0 0 006 f00f 0
14000100 01020700 1000 ff 1234 f 0 007 f0 0
15000000 01020800 1000 1 43 0 0 008 8 0
16000000 01020900 1000 8000000000000000 3f 0 0 009 1 0
17000100 01020a00 1000 8000000000000000 0 4 0 00a f800000000000000 0
18000000 01020b00 1000 ffffffffffffffff 1 0 0 00b 1 0
19000000 01020c00 1000 ffffffffffffffff 1 0 0 00c 0 0
10000010 05020d05 1000 1 2 0 100 00d 102 0
11000010 01060e06 1000 300 9 0 200 00e 100 0
10000010 00020f00 1000 0 7 0 999 00f 7 0
10000110 01061006 1000 10 9 5 200 010 15 0
20000000 01021100 1000 5 5 40 0 111 0 1040
20100000 01021200 1000 5 5 40 0 012 0 1040
20200000 01021300 1000 ffffffffffffffff 1 40 0 113 0 1040
20300000 01021400 1000 ffffffffffffffff 1 40 0 014 0 1040
20400000 01021500 1000 ffffffffffffffff 1 40 0 015 0 1040
20500000 01021600 1000 ffffffffffffffff 1 40 0 116 0 1040
20600000 01021700 1000 0 0 40 0 117 1004 1040
20700000 01021800 1000 2001 0 4 0 118 1004 2004
30000000 01021900 1000 fffffffffffffff9 2 0 0 019 fffffffffffffffd 0
30020000 01021a00 1000 fffffffffffffff9 2 0 0 01a ffffffffffffffff 0
30010000 01021b00 1000 64 7 0 0 01b e 0
30030000 01021c00 1000 64 7 0 0 01c 2 0
30000000 01021d00 1000 2a 0 0 0 01d ffffffffffffffff 0
30020000 01021e00 1000 2a 0 0 0 01e 2a 0
30000000 01021f00 1000 8000000000000000 ffffffffffffffff 0 0 01f 8000000000000000 0
30001000 01020100 1000 12345678fffffff9 2 0 0 001 fffffffffffffffd 0
30031000 01020200 1000 180000000 100000000 0 0 002 ffffffff80000000 0
30001000 01020400 1000 80000000 ffffffff 0 0 004 ffffffff80000000 0
30011000 01020500 1000 ffffffff00000064 7 0 0 005 e 0
30000001 01020600 1000 64 7 0 0 000 0 0
10000000 01020700 1000 1 2 0 0 007 3 0
